// ==== dataCacheSubsystem.f ====
common/cachePkg.sv
common/cacheWayIf.sv
dataCache/dataCacheMemory.sv
dataCache/dataCacheController.sv
dataCache/dataCache.sv
hdl/busMemory.sv
hdl/dataCacheSubsystem.sv
tests/dataCacheTb.sv

// ==== Makefile ====
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dataCacheTb
FILELIST  ?= dataCacheSubsystem.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_TEXT ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Output is shown and scanned for the pass line
run: build
	./$(BUILD_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_TEXT)" { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/dataCacheTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataCacheTb;

    // Hit expectation per table entry
    typedef enum logic [1:0] {
        AnyHit,
        MustHit,
        MustMiss
    } hitCheck_t;

    localparam int AccessTimeout = 200;
    localparam int PoolSize      = 12;
    localparam int RandomCount   = 64;

    logic                clk;
    logic                reset;
    logic                memWrite;
    logic                memRead;
    cachePkg::addr_t     addr;
    cachePkg::word_t     writeData;
    cachePkg::byteMask_t byteMask;
    cachePkg::word_t     readData;
    logic                stall;

    // ----------------------------------------
    // Stimulus table, one column per queue
    // ----------------------------------------
    logic                opTable   [$];
    cachePkg::addr_t     addrTable [$];
    cachePkg::word_t     dataTable [$];
    cachePkg::byteMask_t maskTable [$];
    hitCheck_t           hitTable  [$];

    // Reference model of the backing store
    cachePkg::word_t refMem [cachePkg::MemWords];
    cachePkg::addr_t pool [PoolSize];

    int   errorCount;
    int   checkCount;
    logic timedOut;

    dataCacheSubsystem dut (
        .clk       (clk),
        .reset     (reset),
        .memWrite  (memWrite),
        .memRead   (memRead),
        .addr      (addr),
        .writeData (writeData),
        .byteMask  (byteMask),
        .readData  (readData),
        .stall     (stall)
    );

    // 100 ns period
    always #50 clk = ~clk;

    task automatic addEntry(input logic write, input cachePkg::addr_t a,
                            input cachePkg::word_t d, input cachePkg::byteMask_t m,
                            input hitCheck_t h);
        opTable.push_back(write);
        addrTable.push_back(a);
        dataTable.push_back(d);
        maskTable.push_back(m);
        hitTable.push_back(h);
    endtask

    // Enabled bytes replace the old ones
    function automatic cachePkg::word_t mergeBytes(input cachePkg::word_t old,
                                                   input cachePkg::word_t data,
                                                   input cachePkg::byteMask_t m);
        cachePkg::word_t result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) begin
                result[8*b +: 8] = data[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic int refIndex(input cachePkg::addr_t a);
        return int'(a[2 +: $clog2(cachePkg::MemWords)]);
    endfunction

    task automatic buildDirected();
        // Full word write into empty set 1, then read back
        addEntry(1'b1, 32'h010, 32'h1122_3344, 4'hF, MustMiss);
        addEntry(1'b0, 32'h010, 32'h0, 4'hF, MustHit);
        // Byte lanes on another word of the same block
        addEntry(1'b1, 32'h014, 32'hAABB_CCDD, 4'hF, MustHit);
        addEntry(1'b1, 32'h014, 32'h0000_0055, 4'b0001, MustHit);
        addEntry(1'b1, 32'h014, 32'h6600_0000, 4'b1000, MustHit);
        addEntry(1'b1, 32'h014, 32'h0012_3400, 4'b0110, MustHit);
        addEntry(1'b0, 32'h014, 32'h0, 4'hF, MustHit);
        // Set 2 with blocks A, B and C
        addEntry(1'b1, 32'h020, 32'hA0A0_0001, 4'hF, MustMiss);
        addEntry(1'b1, 32'h060, 32'hB0B0_0002, 4'hF, MustMiss);
        addEntry(1'b0, 32'h020, 32'h0, 4'hF, MustHit);
        // C evicts B, the LRU way
        addEntry(1'b1, 32'h0A0, 32'hC0C0_0003, 4'hF, MustMiss);
        addEntry(1'b0, 32'h020, 32'h0, 4'hF, MustHit);
        addEntry(1'b0, 32'h0A0, 32'h0, 4'hF, MustHit);
        // B and then A come back through their writebacks
        addEntry(1'b0, 32'h060, 32'h0, 4'hF, MustMiss);
        addEntry(1'b0, 32'h020, 32'h0, 4'hF, MustMiss);
    endtask

    task automatic buildRandom();
        cachePkg::addr_t a;
        // Seed every pool word with a full write
        for (int i = 0; i < PoolSize; i++) begin
            pool[i] = cachePkg::addr_t'(($urandom % cachePkg::MemWords) * 4);
            addEntry(1'b1, pool[i], $urandom, 4'hF, AnyHit);
        end
        for (int i = 0; i < RandomCount; i++) begin
            a = pool[$urandom % PoolSize];
            if ($urandom % 2 == 0) begin
                addEntry(1'b1, a, $urandom, cachePkg::byteMask_t'($urandom % 16), AnyHit);
            end else begin
                addEntry(1'b0, a, 32'h0, 4'hF, AnyHit);
            end
        end
    endtask

    // ----------------------------------------
    // One table entry, held until stall falls
    // ----------------------------------------
    task automatic runAccess(input int idx);
        int   cycles;
        logic firstStall;
        int   wordIdx;
        wordIdx = refIndex(addrTable[idx]);
        @(posedge clk);
        memWrite  <= opTable[idx];
        memRead   <= !opTable[idx];
        addr      <= addrTable[idx];
        writeData <= dataTable[idx];
        byteMask  <= maskTable[idx];
        @(negedge clk);
        // A hit never raises stall
        firstStall = stall;
        cycles = 0;
        while (stall && cycles < AccessTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (stall) begin
            $display("access %0d to address %h never completed, stall stayed high",
                     idx, addrTable[idx]);
            errorCount++;
            timedOut = 1'b1;
        end else begin
            if (hitTable[idx] == MustHit) begin
                checkCount++;
                if (firstStall) begin
                    $display("access %0d to address %h stalled although it should hit",
                             idx, addrTable[idx]);
                    errorCount++;
                end
            end
            if (hitTable[idx] == MustMiss) begin
                checkCount++;
                if (!firstStall) begin
                    $display("access %0d to address %h did not stall although it should miss",
                             idx, addrTable[idx]);
                    errorCount++;
                end
            end
            if (opTable[idx]) begin
                refMem[wordIdx] = mergeBytes(refMem[wordIdx], dataTable[idx], maskTable[idx]);
            end else begin
                checkCount++;
                if (readData !== refMem[wordIdx]) begin
                    $display("mismatch readData access %0d addr %h: got %h expected %h",
                             idx, addrTable[idx], readData, refMem[wordIdx]);
                    errorCount++;
                end
            end
        end
    endtask

    initial begin
        void'($urandom(16743));
        clk        = 1'b0;
        reset      = 1'b1;
        memWrite   = 1'b0;
        memRead    = 1'b0;
        addr       = '0;
        writeData  = '0;
        byteMask   = '0;
        errorCount = 0;
        checkCount = 0;
        timedOut   = 1'b0;
        buildDirected();
        buildRandom();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkCount++;
        if (stall) begin
            $display("stall is high after reset with no access pending");
            errorCount++;
        end
        for (int i = 0; i < opTable.size() && !timedOut; i++) begin
            runAccess(i);
        end
        // Core goes idle
        @(posedge clk);
        memRead  <= 1'b0;
        memWrite <= 1'b0;
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/dataCacheSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataCacheSubsystem (
    input  logic                clk,
    input  logic                reset,
    input  logic                memWrite,
    input  logic                memRead,
    input  cachePkg::addr_t     addr,
    input  cachePkg::word_t     writeData,
    input  cachePkg::byteMask_t byteMask,
    output cachePkg::word_t     readData,
    output logic                stall
);

    // Cache to memory bus
    logic            hRequest;
    logic            hWrite;
    cachePkg::addr_t hAddr;
    cachePkg::word_t hWData;
    cachePkg::word_t hRData;
    logic            busReady;

    dataCache cache (
        .clk       (clk),
        .reset     (reset),
        .memRead   (memRead),
        .memWrite  (memWrite),
        .addr      (addr),
        .writeData (writeData),
        .byteMask  (byteMask),
        .hRData    (hRData),
        .busReady  (busReady),
        .readData  (readData),
        .stall     (stall),
        .hRequest  (hRequest),
        .hWrite    (hWrite),
        .hAddr     (hAddr),
        .hWData    (hWData)
    );

    busMemory backing (
        .clk      (clk),
        .reset    (reset),
        .hRequest (hRequest),
        .hWrite   (hWrite),
        .hAddr    (hAddr),
        .hWData   (hWData),
        .hRData   (hRData),
        .busReady (busReady)
    );

endmodule

`default_nettype wire

// ==== hdl/busMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module busMemory (
    input  logic            clk,
    input  logic            reset,
    input  logic            hRequest,
    input  logic            hWrite,
    input  cachePkg::addr_t hAddr,
    input  cachePkg::word_t hWData,
    output cachePkg::word_t hRData,
    output logic            busReady
);

    cachePkg::word_t memory [cachePkg::MemWords];

    // Word address, upper bits ignored
    logic [$clog2(cachePkg::MemWords)-1:0] wordIndex;
    logic [$clog2(cachePkg::WaitStates + 1)-1:0] waitCount;

    assign wordIndex = hAddr[2 +: $clog2(cachePkg::MemWords)];

    // Read word is valid during the ready cycle
    assign hRData = memory[wordIndex];

    // ----------------------------------------
    // Wait state counter
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            waitCount <= '0;
            busReady  <= 1'b0;
        end else if (busReady) begin
            // One cycle pulse only
            busReady <= 1'b0;
        end else if (hRequest) begin
            if (waitCount == $bits(waitCount)'(cachePkg::WaitStates - 1)) begin
                waitCount <= '0;
                busReady  <= 1'b1;
            end else begin
                waitCount <= waitCount + 1'b1;
            end
        end
    end

    // Store on the write beat
    always_ff @(posedge clk) begin
        if (busReady && hRequest && hWrite) begin
            memory[wordIndex] <= hWData;
        end
    end

    readyOnRequest: assert property (@(posedge clk) disable iff (reset)
        busReady |-> hRequest);

endmodule

`default_nettype wire

// ==== dataCache/dataCache.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataCache (
    input  logic                clk,
    input  logic                reset,
    input  logic                memRead,
    input  logic                memWrite,
    input  cachePkg::addr_t     addr,
    input  cachePkg::word_t     writeData,
    input  cachePkg::byteMask_t byteMask,
    input  cachePkg::word_t     hRData,
    input  logic                busReady,
    output cachePkg::word_t     readData,
    output logic                stall,
    output logic                hRequest,
    output logic                hWrite,
    output cachePkg::addr_t     hAddr,
    output cachePkg::word_t     hWData
);

    cacheWayIf wayBus ();

    cachePkg::offset_t   wordCount;
    logic                useRequestOffset;
    cachePkg::addr_t     effAddr;
    cachePkg::addr_t     victimAddr;
    cachePkg::tag_t      victimTag;
    cachePkg::word_t     writeWord;
    cachePkg::byteMask_t activeMask;
    cachePkg::word_t     way1Word;
    cachePkg::word_t     way2Word;
    cachePkg::tag_t      way1Tag;
    cachePkg::tag_t      way2Tag;

    // ----------------------------------------
    // Address generation
    // ----------------------------------------
    // Beat counter replaces the word offset during bus transfers
    assign effAddr = useRequestOffset ? addr
                   : {addr[31:2 + cachePkg::OffsetBits], wordCount, addr[1:0]};

    // Writeback goes to the victim's own block
    assign victimTag  = wayBus.wayEnable1 ? way1Tag : way2Tag;
    assign victimAddr = {victimTag, effAddr[31 - cachePkg::TagBits:0]};
    assign hAddr      = hWrite ? victimAddr : effAddr;

    // Core data with its mask, or a full bus word
    assign writeWord  = wayBus.useCoreData ? writeData : hRData;
    assign activeMask = wayBus.useCoreData ? byteMask : 4'b1111;

    // Victim word out on writeback
    assign hWData = wayBus.wayEnable1 ? way1Word : way2Word;

    // Hit way to the core
    assign readData = wayBus.hit1 ? way1Word : way2Word;

    dataCacheMemory memory (
        .clk        (clk),
        .reset      (reset),
        .addr       (effAddr),
        .writeWord  (writeWord),
        .activeMask (activeMask),
        .ctrl       (wayBus),
        .way1Word   (way1Word),
        .way2Word   (way2Word),
        .way1Tag    (way1Tag),
        .way2Tag    (way2Tag)
    );

    dataCacheController controller (
        .clk              (clk),
        .reset            (reset),
        .memRead          (memRead),
        .memWrite         (memWrite),
        .busReady         (busReady),
        .ctrl             (wayBus),
        .wordCount        (wordCount),
        .useRequestOffset (useRequestOffset),
        .stall            (stall),
        .hRequest         (hRequest),
        .hWrite           (hWrite)
    );

endmodule

`default_nettype wire

// ==== dataCache/dataCacheController.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataCacheController (
    input  logic              clk,
    input  logic              reset,
    input  logic              memRead,
    input  logic              memWrite,
    input  logic              busReady,
    cacheWayIf.controller     ctrl,
    output cachePkg::offset_t wordCount,
    output logic              useRequestOffset,
    output logic              stall,
    output logic              hRequest,
    output logic              hWrite
);

    cachePkg::cacheState_t state;
    cachePkg::cacheState_t nextState;

    logic access;
    logic hit;
    logic lastBeat;
    // Victim way, 0 is way 1
    logic missWay;
    logic missDirty;
    logic victimWay;

    assign access   = memRead || memWrite;
    assign hit      = ctrl.hit1 || ctrl.hit2;
    assign lastBeat = (wordCount == cachePkg::offset_t'(cachePkg::BlockWords - 1));

    // Invalid way first, else the LRU way
    assign missWay   = !ctrl.valid1 ? 1'b0 : (!ctrl.valid2 ? 1'b1 : ctrl.lruWay);
    assign missDirty = missWay ? (ctrl.valid2 && ctrl.dirty2) : (ctrl.valid1 && ctrl.dirty1);

    // ----------------------------------------
    // State, victim and beat counter
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= cachePkg::Ready;
            victimWay <= 1'b0;
            wordCount <= '0;
        end else begin
            state <= nextState;
            if (state == cachePkg::Ready && access && !hit) begin
                victimWay <= missWay;
            end
            // Counter wraps to zero after the last beat
            if (hRequest && busReady) begin
                wordCount <= wordCount + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Next state and outputs
    // ----------------------------------------
    always_comb begin
        nextState        = state;
        stall            = 1'b0;
        hRequest         = 1'b0;
        hWrite           = 1'b0;
        useRequestOffset = 1'b1;
        ctrl.wayEnable1  = 1'b0;
        ctrl.wayEnable2  = 1'b0;
        ctrl.writeEnable = 1'b0;
        ctrl.blockWrite  = 1'b0;
        ctrl.dirtyIn     = 1'b0;
        ctrl.useCoreData = 1'b1;
        ctrl.updateLru   = 1'b0;
        case (state)
            cachePkg::Ready, cachePkg::Finish: begin
                // Core access on the hit way
                ctrl.wayEnable1  = ctrl.hit1;
                ctrl.wayEnable2  = ctrl.hit2;
                ctrl.writeEnable = memWrite && hit;
                ctrl.dirtyIn     = 1'b1;
                ctrl.updateLru   = access && hit;
                if (state == cachePkg::Finish) begin
                    nextState = cachePkg::Ready;
                end else if (access && !hit) begin
                    stall     = 1'b1;
                    nextState = missDirty ? cachePkg::WriteBack : cachePkg::Refill;
                end
            end
            cachePkg::WriteBack: begin
                stall            = 1'b1;
                hRequest         = 1'b1;
                hWrite           = 1'b1;
                useRequestOffset = 1'b0;
                ctrl.wayEnable1  = !victimWay;
                ctrl.wayEnable2  = victimWay;
                if (busReady && lastBeat) begin
                    nextState = cachePkg::Refill;
                end
            end
            cachePkg::Refill: begin
                stall            = 1'b1;
                hRequest         = 1'b1;
                useRequestOffset = 1'b0;
                ctrl.wayEnable1  = !victimWay;
                ctrl.wayEnable2  = victimWay;
                // Bus word lands at the ready beat, line comes in clean
                ctrl.writeEnable = busReady;
                ctrl.blockWrite  = 1'b1;
                ctrl.useCoreData = 1'b0;
                if (busReady && lastBeat) begin
                    nextState = cachePkg::Finish;
                end
            end
            default: begin
                nextState = cachePkg::Ready;
            end
        endcase
    end

    // Writeback beat is followed by another beat or by the refill
    writeNeedsRequest: assert property (@(posedge clk) disable iff (reset)
        hWrite |-> hRequest ##1 hRequest);

    // Bus beat held until busReady
    beatHeld: assert property (@(posedge clk) disable iff (reset)
        (hRequest && !busReady) |=> (hRequest && $stable(hWrite) && $stable(wordCount)));

    // Stall only drops into the Finish cycle
    busyStalls: assert property (@(posedge clk) disable iff (reset)
        stall |=> (stall || state == cachePkg::Finish));

endmodule

`default_nettype wire

// ==== dataCache/dataCacheMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataCacheMemory (
    input  logic                clk,
    input  logic                reset,
    input  cachePkg::addr_t     addr,
    input  cachePkg::word_t     writeWord,
    input  cachePkg::byteMask_t activeMask,
    cacheWayIf.memory           ctrl,
    output cachePkg::word_t     way1Word,
    output cachePkg::word_t     way2Word,
    output cachePkg::tag_t      way1Tag,
    output cachePkg::tag_t      way2Tag
);

    // Address fields, byte offset is the low 2 bits
    cachePkg::tag_t    addrTag;
    cachePkg::set_t    setIdx;
    cachePkg::offset_t wordIdx;

    // Way storage, index 0 is way 1
    cachePkg::word_t wayData [2][cachePkg::SetCount][cachePkg::BlockWords];
    cachePkg::tag_t  wayTags [2][cachePkg::SetCount];
    logic [cachePkg::SetCount-1:0] validBits [2];
    logic [cachePkg::SetCount-1:0] dirtyBits [2];
    logic [cachePkg::SetCount-1:0] lruBits;

    // Per way write strobe
    logic [1:0] wayWrite;

    assign addrTag = addr[31 -: cachePkg::TagBits];
    assign setIdx  = addr[2 + cachePkg::OffsetBits +: cachePkg::SetBits];
    assign wordIdx = addr[2 +: cachePkg::OffsetBits];

    assign wayWrite = {2{ctrl.writeEnable}} & {ctrl.wayEnable2, ctrl.wayEnable1};

    // ----------------------------------------
    // Lookup
    // ----------------------------------------
    assign way1Word = wayData[0][setIdx][wordIdx];
    assign way2Word = wayData[1][setIdx][wordIdx];
    assign way1Tag  = wayTags[0][setIdx];
    assign way2Tag  = wayTags[1][setIdx];

    assign ctrl.valid1 = validBits[0][setIdx];
    assign ctrl.valid2 = validBits[1][setIdx];
    assign ctrl.dirty1 = dirtyBits[0][setIdx];
    assign ctrl.dirty2 = dirtyBits[1][setIdx];
    assign ctrl.lruWay = lruBits[setIdx];

    // Tag compare, gated by valid
    assign ctrl.hit1 = validBits[0][setIdx] && (wayTags[0][setIdx] == addrTag);
    assign ctrl.hit2 = validBits[1][setIdx] && (wayTags[1][setIdx] == addrTag);

    // ----------------------------------------
    // Data and tag arrays
    // ----------------------------------------
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wayWrite[w]) begin
                // Byte lane merge
                for (int b = 0; b < 4; b++) begin
                    if (activeMask[b]) begin
                        wayData[w][setIdx][wordIdx][8*b +: 8] <= writeWord[8*b +: 8];
                    end
                end
                // Refill claims the line for the new tag
                if (ctrl.blockWrite) begin
                    wayTags[w][setIdx] <= addrTag;
                end
            end
        end
    end

    // Status bits
    always_ff @(posedge clk) begin
        if (reset) begin
            validBits[0] <= '0;
            validBits[1] <= '0;
            dirtyBits[0] <= '0;
            dirtyBits[1] <= '0;
            lruBits      <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wayWrite[w]) begin
                    dirtyBits[w][setIdx] <= ctrl.dirtyIn;
                    if (ctrl.blockWrite) begin
                        validBits[w][setIdx] <= 1'b1;
                    end
                end
            end
            // Hit in way 1 leaves way 2 as LRU
            if (ctrl.updateLru) begin
                lruBits[setIdx] <= ctrl.hit1;
            end
        end
    end

    // A block lives in one way only
    hitOneHot: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.hit1 && ctrl.hit2));

    writeOneWay: assert property (@(posedge clk) disable iff (reset)
        ctrl.writeEnable |-> !(ctrl.wayEnable1 && ctrl.wayEnable2));

endmodule

`default_nettype wire

// ==== common/cacheWayIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// Control bundle between the cache FSM and the way arrays
interface cacheWayIf;

    // Controller side strobes
    logic wayEnable1;
    logic wayEnable2;
    logic writeEnable;
    logic blockWrite;
    logic dirtyIn;
    logic useCoreData;
    logic updateLru;

    // Status of the addressed set
    logic hit1;
    logic hit2;
    logic valid1;
    logic valid2;
    logic dirty1;
    logic dirty2;
    // Least recently used way, 0 is way 1
    logic lruWay;

    modport controller (
        output wayEnable1, wayEnable2, writeEnable, blockWrite, dirtyIn, useCoreData, updateLru,
        input  hit1, hit2, valid1, valid2, dirty1, dirty2, lruWay
    );

    modport memory (
        input  wayEnable1, wayEnable2, writeEnable, blockWrite, dirtyIn, useCoreData, updateLru,
        output hit1, hit2, valid1, valid2, dirty1, dirty2, lruWay
    );

endinterface

`default_nettype wire

// ==== common/cachePkg.sv ====
`default_nettype none

package cachePkg;

    // ----------------------------------------
    // Cache geometry
    // ----------------------------------------
    localparam int WordBits   = 32;
    localparam int BlockWords = 4;
    localparam int SetCount   = 4;
    localparam int OffsetBits = 2;
    localparam int SetBits    = 2;
    // 32 address bits minus byte, word offset and set fields
    localparam int TagBits    = 32 - 2 - OffsetBits - SetBits;

    // ----------------------------------------
    // Backing memory
    // ----------------------------------------
    localparam int MemWords   = 256;
    // Cycles from request to busReady
    localparam int WaitStates = 2;

    // Address and data fields
    typedef logic [WordBits-1:0]   word_t;
    typedef logic [31:0]           addr_t;
    typedef logic [TagBits-1:0]    tag_t;
    typedef logic [SetBits-1:0]    set_t;
    typedef logic [OffsetBits-1:0] offset_t;
    typedef logic [3:0]            byteMask_t;

    // Miss handling FSM
    typedef enum logic [1:0] {
        Ready,
        WriteBack,
        Refill,
        Finish
    } cacheState_t;

endpackage

`default_nettype wire
